//--- agq_replay.f
+incdir+src
src/agq_pkg.sv
src/agq_slot_if.sv
src/agq_mop_store.sv
src/agq_slot_tracker.sv
src/agq_lane_replay.sv
src/agq_replay_top.sv
dv/agq_tb_assertions.sv
dv/agq_tb.sv

//--- dv/agq_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "agq_consts.svh"

module agq_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 5;
  // cycle budget of each test
  localparam int T_SINGLE = 30;
  localparam int T_MIXED  = 60;
  localparam int T_SKIP   = 50;
  localparam int T_STALL  = 50;
  localparam int T_FLUSH  = 50;
  localparam int WATCHDOG_NS =
    2 * (RESET_CYCLES + T_SINGLE + T_MIXED + T_SKIP + T_STALL + T_FLUSH) * CLK_PERIOD;

  // expected replayed micro-op
  typedef struct packed {
    logic [`AGQ_VADDR_W-1:0] addr;
    logic [`AGQ_REG_W-1:0]   reg_no;
    logic [1:0]              op_type;
    logic [4:0]              sz;
    logic [`AGQ_LSQ_W-1:0]   lsq;
    logic [3:0]              attr;
  } exp_mop_t;

  logic                    clk;
  logic                    rst;
  logic                    except;
  logic                    read_clk_en;
  logic                    rs_stall;
  logic [2:0]              conflict;
  logic [`AGQ_VADDR_W-1:0] lane_addr   [3];
  logic [`AGQ_REG_W-1:0]   lane_reg_no [3];
  logic [1:0]              lane_type   [3];
  logic [4:0]              lane_sz     [3];
  logic [`AGQ_LSQ_W-1:0]   lane_lsq    [3];
  logic [3:0]              lane_attr   [3];

  logic                    mop_r_en;
  logic [`AGQ_VADDR_W-1:0] mop_r_addr;
  logic [`AGQ_REG_W-1:0]   mop_r_reg_no;
  logic [1:0]              mop_r_type;
  logic [4:0]              mop_r_sz;
  logic [`AGQ_LSQ_W-1:0]   mop_r_lsq;
  logic [3:0]              mop_r_attr;
  logic                    do_skip;

  // model queue of groups in arrival order with lanes ascending
  exp_mop_t exp_q [$];
  int       errors;
  int       pulses;

  agq_replay_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .except       (except),
    .read_clk_en  (read_clk_en),
    .rs_stall     (rs_stall),
    .conflict0    (conflict[0]),
    .mop0_addr    (lane_addr[0]),
    .mop0_reg_no  (lane_reg_no[0]),
    .mop0_type    (lane_type[0]),
    .mop0_sz      (lane_sz[0]),
    .mop0_lsq     (lane_lsq[0]),
    .mop0_attr    (lane_attr[0]),
    .conflict1    (conflict[1]),
    .mop1_addr    (lane_addr[1]),
    .mop1_reg_no  (lane_reg_no[1]),
    .mop1_type    (lane_type[1]),
    .mop1_sz      (lane_sz[1]),
    .mop1_lsq     (lane_lsq[1]),
    .mop1_attr    (lane_attr[1]),
    .conflict2    (conflict[2]),
    .mop2_addr    (lane_addr[2]),
    .mop2_reg_no  (lane_reg_no[2]),
    .mop2_type    (lane_type[2]),
    .mop2_sz      (lane_sz[2]),
    .mop2_lsq     (lane_lsq[2]),
    .mop2_attr    (lane_attr[2]),
    .mop_r_en     (mop_r_en),
    .mop_r_addr   (mop_r_addr),
    .mop_r_reg_no (mop_r_reg_no),
    .mop_r_type   (mop_r_type),
    .mop_r_sz     (mop_r_sz),
    .mop_r_lsq    (mop_r_lsq),
    .mop_r_attr   (mop_r_attr),
    .do_skip      (do_skip)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    if (got !== want) begin
      errors++;
      $display("ERROR %s got %h expected %h at %0t", name, got, want, $time);
    end
  endtask

  // replays are sampled at the falling edge where the outputs have settled
  always @(negedge clk) begin
    exp_mop_t want;
    if (!rst && mop_r_en) begin
      pulses++;
      if (rs_stall || except) begin
        errors++;
        $display("replay issued while rs_stall or except was high at %0t", $time);
      end
      if (exp_q.size() == 0) begin
        errors++;
        $display("unexpected replay with lsq tag %h at %0t", mop_r_lsq, $time);
      end else begin
        want = exp_q.pop_front();
        compare_value("mop_r_addr", mop_r_addr, want.addr);
        compare_value("mop_r_reg_no", mop_r_reg_no, want.reg_no);
        compare_value("mop_r_type", mop_r_type, want.op_type);
        compare_value("mop_r_sz", mop_r_sz, want.sz);
        compare_value("mop_r_lsq", mop_r_lsq, want.lsq);
        compare_value("mop_r_attr", mop_r_attr, want.attr);
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // drive one group for one cycle and record the lanes that will replay
  task automatic offer_group(input logic [2:0] mask);
    exp_mop_t    m;
    logic [63:0] r;
    logic        captured;
    captured = (|mask) && !except && !rs_stall;
    for (int i = 0; i < 3; i++) begin
      r = {$urandom(), $urandom()};
      m.addr = r[`AGQ_VADDR_W-1:0];
      r = {$urandom(), $urandom()};
      m.reg_no  = r[`AGQ_REG_W-1:0];
      m.op_type = r[17:16];
      m.sz      = r[24:20];
      m.lsq     = r[40:32];
      m.attr    = r[51:48];
      lane_addr[i]   = m.addr;
      lane_reg_no[i] = m.reg_no;
      lane_type[i]   = m.op_type;
      lane_sz[i]     = m.sz;
      lane_lsq[i]    = m.lsq;
      lane_attr[i]   = m.attr;
      if (captured && mask[i]) begin
        exp_q.push_back(m);
      end
    end
    conflict = mask;
    next_cycle();
    conflict = '0;
  endtask

  task automatic wait_drained(input int max_cycles, input string test_name,
                              input bit skip_held);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(negedge clk);
      #1;
      if (skip_held && exp_q.size() != 0 && !do_skip) begin
        errors++;
        $display("%s: do_skip fell while lanes were still pending", test_name);
      end
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d lanes not replayed within %0d cycles", test_name, exp_q.size(),
               max_cycles);
    end
  endtask

  task automatic check_idle();
    @(negedge clk);
    compare_value("mop_r_en", mop_r_en, 0);
    compare_value("mop_r_addr", mop_r_addr, 0);
    compare_value("mop_r_reg_no", mop_r_reg_no, 0);
    compare_value("mop_r_type", mop_r_type, 0);
    compare_value("mop_r_sz", mop_r_sz, 0);
    compare_value("mop_r_lsq", mop_r_lsq, 0);
    compare_value("mop_r_attr", mop_r_attr, 0);
  endtask

  task automatic test_single_lane();
    int start;
    start = pulses;
    read_clk_en = 1'b1;
    offer_group(3'b010);
    wait_drained(T_SINGLE, "single lane", 1'b0);
    repeat (3) check_idle();
    compare_value("mop_r_en pulse count", pulses - start, 1);
    next_cycle();
  endtask

  task automatic test_mixed_groups();
    logic [2:0] masks [7] = '{3'b101, 3'b000, 3'b111, 3'b011, 3'b000, 3'b100, 3'b110};
    int start;
    int lanes;
    start = pulses;
    lanes = 0;
    read_clk_en = 1'b1;
    for (int i = 0; i < 7; i++) begin
      lanes += $countones(masks[i]);
      offer_group(masks[i]);
    end
    wait_drained(T_MIXED, "mixed groups", 1'b0);
    repeat (3) check_idle();
    compare_value("mop_r_en pulse count", pulses - start, lanes);
    next_cycle();
  endtask

  task automatic test_skip_warning();
    int n;
    read_clk_en = 1'b0;
    offer_group(3'b001);
    offer_group(3'b110);
    offer_group(3'b111);
    // occupancy was two before this edge
    compare_value("do_skip", do_skip, 0);
    n = 0;
    while (!do_skip && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (!do_skip) begin
      errors++;
      $display("do_skip never rose with three groups stored");
    end
    next_cycle();
    read_clk_en = 1'b1;
    wait_drained(T_SKIP, "skip warning", 1'b1);
    n = 0;
    while (do_skip && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (do_skip) begin
      errors++;
      $display("do_skip stayed high after the queue emptied");
    end
    next_cycle();
  endtask

  task automatic test_stall_midway();
    int start;
    start = pulses;
    read_clk_en = 1'b1;
    offer_group(3'b111);
    // lane 0 of the first group replays in this cycle
    offer_group(3'b011);
    compare_value("mop_r_en pulses before stall", pulses - start, 1);
    rs_stall = 1'b1;
    repeat (4) offer_group(3'b101);
    rs_stall = 1'b0;
    wait_drained(T_STALL, "stall", 1'b0);
    repeat (3) check_idle();
    compare_value("mop_r_en pulse count", pulses - start, 5);
    next_cycle();
  endtask

  task automatic test_flush();
    int start;
    read_clk_en = 1'b0;
    offer_group(3'b110);
    offer_group(3'b011);
    start = pulses;
    // flush empties the ring and blocks both replay and the group offered with it
    except = 1'b1;
    read_clk_en = 1'b1;
    exp_q.delete();
    offer_group(3'b001);
    except = 1'b0;
    repeat (6) next_cycle();
    compare_value("mop_r_en pulses after flush", pulses - start, 0);
    offer_group(3'b100);
    wait_drained(T_FLUSH, "flush", 1'b0);
    repeat (3) check_idle();
    compare_value("mop_r_en pulse count", pulses - start, 1);
    next_cycle();
  endtask

  initial begin
    void'($urandom(32'h6dd8_0486));
    errors      = 0;
    pulses      = 0;
    rst         = 1'b1;
    except      = 1'b0;
    read_clk_en = 1'b0;
    rs_stall    = 1'b0;
    conflict    = '0;
    for (int i = 0; i < 3; i++) begin
      lane_addr[i]   = '0;
      lane_reg_no[i] = '0;
      lane_type[i]   = '0;
      lane_sz[i]     = '0;
      lane_lsq[i]    = '0;
      lane_attr[i]   = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    test_single_lane();
    test_mixed_groups();
    test_skip_warning();
    test_stall_midway();
    test_flush();
    $display("tests finished with %0d check errors and %0d assertion failures", errors,
             dut0.chk0.failures);
    if (errors == 0 && dut0.chk0.failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/agq_tb_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "agq_consts.svh"

module agq_tb_assertions (
  input logic                    clk,
  input logic                    rst,
  input logic                    except,
  input logic                    rs_stall,
  input logic                    mop_r_en,
  input logic [`AGQ_VADDR_W-1:0] mop_r_addr,
  input logic [`AGQ_REG_W-1:0]   mop_r_reg_no,
  input logic [1:0]              mop_r_type,
  input logic [4:0]              mop_r_sz,
  input logic [`AGQ_LSQ_W-1:0]   mop_r_lsq,
  input logic [3:0]              mop_r_attr,
  input logic                    do_skip
);

  // count of failed assertions
  int failures = 0;

  // no replay while stalled or flushing
  assert property (@(posedge clk) disable iff (rst) (rs_stall || except) |-> !mop_r_en)
    else begin
      failures++;
      $error("mop_r_en high during rs_stall or except");
    end

  // idle replay bus carries zeros
  assert property (@(posedge clk) disable iff (rst)
    !mop_r_en |-> (mop_r_addr == '0 && mop_r_reg_no == '0 && mop_r_type == '0 &&
                   mop_r_sz == '0 && mop_r_lsq == '0 && mop_r_attr == '0))
    else begin
      failures++;
      $error("mop_r fields nonzero while mop_r_en is low");
    end

  assert property (@(posedge clk) rst |=> !do_skip)
    else begin
      failures++;
      $error("do_skip high after reset");
    end

endmodule

bind agq_replay_top agq_tb_assertions chk0 (
  .clk          (clk),
  .rst          (rst),
  .except       (except),
  .rs_stall     (rs_stall),
  .mop_r_en     (mop_r_en),
  .mop_r_addr   (mop_r_addr),
  .mop_r_reg_no (mop_r_reg_no),
  .mop_r_type   (mop_r_type),
  .mop_r_sz     (mop_r_sz),
  .mop_r_lsq    (mop_r_lsq),
  .mop_r_attr   (mop_r_attr),
  .do_skip      (do_skip)
);

`default_nettype wire

//--- src/agq_consts.svh
`ifndef AGQ_CONSTS_SVH
`define AGQ_CONSTS_SVH

// ring geometry
`define AGQ_DEPTH       8
`define AGQ_PTR_W       3

// micro-ops offered per cycle
`define AGQ_LANES       3

// micro-op field widths
`define AGQ_VADDR_W     44
`define AGQ_REG_W       6
`define AGQ_LSQ_W       9

// occupancy that warns upstream to skip
`define AGQ_SKIP_LEVEL  3

`endif

//--- src/agq_lane_replay.sv
`timescale 1ns/1ps
`default_nettype none

`include "agq_consts.svh"

module agq_lane_replay
  import agq_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          read_clk_en,
  input  slot_t         head_slot,
  agq_slot_if.replay    slots,
  output logic          mop_r_en,
  output mop_t          mop_r
);

  localparam int LANE_W = $clog2(`AGQ_LANES);

  lane_mask_t        done;
  lane_mask_t        pending;
  lane_mask_t        sel_oh;
  logic [LANE_W-1:0] sel_idx;
  logic              last_lane;

  // conflict lanes of a live head not yet replayed
  assign pending = head_slot.confl & ~done & {`AGQ_LANES{slots.head_valid}};

  // lowest pending lane wins
  always_comb begin
    sel_idx = '0;
    sel_oh  = '0;
    for (int i = `AGQ_LANES - 1; i >= 0; i--) begin
      if (pending[i]) begin
        sel_idx = LANE_W'(i);
        sel_oh  = lane_mask_t'(1) << i;
      end
    end
  end

  assign last_lane = (pending & ~sel_oh) == '0;

  assign mop_r_en   = (|pending) & read_clk_en;
  assign slots.step = mop_r_en & last_lane;

  // zero the bus when nothing issues
  assign mop_r = mop_r_en ? head_slot.mops[sel_idx] : '0;

  always_ff @(posedge clk) begin
    if (rst || slots.flush) begin
      done <= '0;
    end else if (mop_r_en) begin
      if (last_lane) begin
        // head slot is freed, start fresh for the next group
        done <= '0;
      end else begin
        done <= done | sel_oh;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/agq_mop_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "agq_consts.svh"

module agq_mop_store
  import agq_pkg::*;
(
  input  logic          clk,
  input  slot_t         wr_slot,
  agq_slot_if.store     slots,
  output slot_t         head_slot
);

  // slot storage, occupancy lives in the tracker
  slot_t mem [`AGQ_DEPTH];

  always_ff @(posedge clk) begin
    if (slots.wen) begin
      mem[slots.wr_ptr] <= wr_slot;
    end
  end

  // head read, combinational at the registered pointer
  assign head_slot = mem[slots.rd_ptr];

endmodule

`default_nettype wire

//--- src/agq_pkg.sv
`default_nettype none

`include "agq_consts.svh"

package agq_pkg;

  // one bit per lane, lane 0 in bit 0
  typedef logic [`AGQ_LANES-1:0] lane_mask_t;

  // one memory micro-op, 70 bits
  typedef struct packed {
    logic [`AGQ_VADDR_W-1:0] addr;
    logic [`AGQ_REG_W-1:0]   reg_no;
    logic [1:0]              op_type;
    logic [4:0]              sz;
    logic [`AGQ_LSQ_W-1:0]   lsq;
    logic [3:0]              attr;
  } mop_t;

  // one stored group: conflict lanes plus all three micro-ops
  typedef struct packed {
    lane_mask_t                 confl;
    mop_t [`AGQ_LANES-1:0]      mops;
  } slot_t;

endpackage

`default_nettype wire

//--- src/agq_replay_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "agq_consts.svh"

module agq_replay_top
  import agq_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    except,
  input  logic                    read_clk_en,
  input  logic                    rs_stall,

  input  logic                    conflict0,
  input  logic [`AGQ_VADDR_W-1:0] mop0_addr,
  input  logic [`AGQ_REG_W-1:0]   mop0_reg_no,
  input  logic [1:0]              mop0_type,
  input  logic [4:0]              mop0_sz,
  input  logic [`AGQ_LSQ_W-1:0]   mop0_lsq,
  input  logic [3:0]              mop0_attr,

  input  logic                    conflict1,
  input  logic [`AGQ_VADDR_W-1:0] mop1_addr,
  input  logic [`AGQ_REG_W-1:0]   mop1_reg_no,
  input  logic [1:0]              mop1_type,
  input  logic [4:0]              mop1_sz,
  input  logic [`AGQ_LSQ_W-1:0]   mop1_lsq,
  input  logic [3:0]              mop1_attr,

  input  logic                    conflict2,
  input  logic [`AGQ_VADDR_W-1:0] mop2_addr,
  input  logic [`AGQ_REG_W-1:0]   mop2_reg_no,
  input  logic [1:0]              mop2_type,
  input  logic [4:0]              mop2_sz,
  input  logic [`AGQ_LSQ_W-1:0]   mop2_lsq,
  input  logic [3:0]              mop2_attr,

  output logic                    mop_r_en,
  output logic [`AGQ_VADDR_W-1:0] mop_r_addr,
  output logic [`AGQ_REG_W-1:0]   mop_r_reg_no,
  output logic [1:0]              mop_r_type,
  output logic [4:0]              mop_r_sz,
  output logic [`AGQ_LSQ_W-1:0]   mop_r_lsq,
  output logic [3:0]              mop_r_attr,
  output logic                    do_skip
);

  lane_mask_t conflicts;
  slot_t      wr_slot;
  slot_t      head_slot;
  mop_t       mop_r;

  agq_slot_if slots ();

  assign conflicts = {conflict2, conflict1, conflict0};

  // incoming group, all three lanes kept so lane index stays fixed
  assign wr_slot.confl   = conflicts;
  assign wr_slot.mops[0] = '{addr: mop0_addr, reg_no: mop0_reg_no, op_type: mop0_type,
                             sz: mop0_sz, lsq: mop0_lsq, attr: mop0_attr};
  assign wr_slot.mops[1] = '{addr: mop1_addr, reg_no: mop1_reg_no, op_type: mop1_type,
                             sz: mop1_sz, lsq: mop1_lsq, attr: mop1_attr};
  assign wr_slot.mops[2] = '{addr: mop2_addr, reg_no: mop2_reg_no, op_type: mop2_type,
                             sz: mop2_sz, lsq: mop2_lsq, attr: mop2_attr};

  agq_slot_tracker tracker0 (
    .clk       (clk),
    .rst       (rst),
    .except    (except),
    .rs_stall  (rs_stall),
    .conflicts (conflicts),
    .slots     (slots.tracker),
    .do_skip   (do_skip)
  );

  agq_mop_store store0 (
    .clk       (clk),
    .wr_slot   (wr_slot),
    .slots     (slots.store),
    .head_slot (head_slot)
  );

  agq_lane_replay replay0 (
    .clk         (clk),
    .rst         (rst),
    .read_clk_en (read_clk_en),
    .head_slot   (head_slot),
    .slots       (slots.replay),
    .mop_r_en    (mop_r_en),
    .mop_r       (mop_r)
  );

  // replayed micro-op back onto flat ports
  assign mop_r_addr   = mop_r.addr;
  assign mop_r_reg_no = mop_r.reg_no;
  assign mop_r_type   = mop_r.op_type;
  assign mop_r_sz     = mop_r.sz;
  assign mop_r_lsq    = mop_r.lsq;
  assign mop_r_attr   = mop_r.attr;

endmodule

`default_nettype wire

//--- src/agq_slot_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "agq_consts.svh"

interface agq_slot_if;

  logic                  wen;
  logic [`AGQ_PTR_W-1:0] wr_ptr;
  logic [`AGQ_PTR_W-1:0] rd_ptr;
  logic                  head_valid;
  logic                  flush;
  // head group fully replayed
  logic                  step;

  modport tracker (output wen, wr_ptr, rd_ptr, head_valid, flush, input step);

  modport store (input wen, wr_ptr, rd_ptr);

  modport replay (input head_valid, flush, output step);

endinterface

`default_nettype wire

//--- src/agq_slot_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "agq_consts.svh"

module agq_slot_tracker
  import agq_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          except,
  input  logic          rs_stall,
  input  lane_mask_t    conflicts,
  agq_slot_if.tracker   slots,
  output logic          do_skip
);

  localparam int CNT_W = $clog2(`AGQ_DEPTH + 1);
  localparam logic [CNT_W-1:0] SKIP_LEVEL = `AGQ_SKIP_LEVEL;

  logic [`AGQ_DEPTH-1:0]  valid;
  logic [`AGQ_PTR_W-1:0]  wr_ptr;
  logic [`AGQ_PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]       occupancy;
  logic                   ring_full;
  logic                   offered;
  logic                   capture;

  // write slot still busy, an offered group is dropped
  assign ring_full = valid[wr_ptr];
  assign offered   = |conflicts;
  assign capture   = offered & ~except & ~rs_stall & ~ring_full;

  assign slots.wen        = capture;
  assign slots.wr_ptr     = wr_ptr;
  assign slots.rd_ptr     = rd_ptr;
  assign slots.flush      = except;
  // head hidden while stalled or flushing
  assign slots.head_valid = valid[rd_ptr] & ~rs_stall & ~except;

  always_comb begin
    occupancy = '0;
    for (int i = 0; i < `AGQ_DEPTH; i++) begin
      occupancy = occupancy + CNT_W'(valid[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid  <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (except) begin
      // flush drops every stored group
      valid  <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (!rs_stall) begin
      if (capture) begin
        valid[wr_ptr] <= 1'b1;
        wr_ptr        <= wr_ptr + 1'b1;
      end
      if (slots.step) begin
        valid[rd_ptr] <= 1'b0;
        rd_ptr        <= rd_ptr + 1'b1;
      end
    end
  end

  // skip warning with hysteresis: set at level, cleared only when empty
  always_ff @(posedge clk) begin
    if (rst) begin
      do_skip <= 1'b0;
    end else if (occupancy >= SKIP_LEVEL) begin
      do_skip <= 1'b1;
    end else if (occupancy == '0) begin
      do_skip <= 1'b0;
    end
  end

endmodule

`default_nettype wire
